// File: files.f
+incdir+hdl
hdl/dma_write_pkg.sv
hdl/dma_write_regs.sv
hdl/dma_write_fifo.sv
hdl/dma_write_fifo2axis.sv
hdl/dma_write_burst_ctrl.sv
hdl/dma_write_axi_wr.sv
hdl/dma_write_top.sv
sim/dma_write_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DMA write testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f files.f \
   --top-module dma_write_tb \
   -o dma_write_sim

./obj_dir/dma_write_sim 2>&1 | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: sim/dma_write_tb.sv
`timescale 1ns/1ps

`include "dma_write_consts.svh"

module dma_write_tb
   import dma_write_pkg::*;
();

   localparam int          NUM_XFER = 10;
   localparam int          CLK_HALF = 20;
   localparam int unsigned SEED     = 32'hd7baa8d5;

   logic                   clk_i = 1'b0;
   logic                   arst_n_i;
   logic                   reg_wr_i;
   logic [`DMA_REG_AW-1:0] reg_addr_i;
   data_t                  reg_wdata_i;
   data_t                  reg_rdata_o;
   logic                   s_tvalid_i = 1'b0;
   data_t                  s_tdata_i = '0;
   logic                   s_tready_o;
   logic                   awvalid_o;
   logic                   awready_i = 1'b0;
   addr_t                  awaddr_o;
   logic [`DMA_BLEN_W-2:0] awlen_o;
   logic                   wvalid_o;
   logic                   wready_i = 1'b0;
   data_t                  wdata_o;
   logic                   wlast_o;
   logic                   bvalid_i = 1'b0;
   logic                   bready_o;
   logic                   busy_o;

   // Stream source state
   data_t src_q[$];
   int    src_idx = 0;
   int    src_shown = 0;
   int    gap_pct;
   int    stall_pct;

   // AXI slave model state
   addr_t aw_addr_q[$];
   blen_t aw_len_q[$];
   blen_t resp_len_q[$];
   addr_t wr_addr_q[$];
   data_t mem [addr_t];
   int    w_idx = 0;
   int    w_beat = 0;
   int    b_done = 0;
   int    b_mark = 0;
   int    acked = 0;
   int    tready_low = 0;

   wlen_t xfer_len [NUM_XFER];
   blen_t xfer_max [NUM_XFER];
   addr_t xfer_addr [NUM_XFER];
   int    total_words;
   int    word_seq;

   dma_write_top u_dma_write_top (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .reg_wr_i   (reg_wr_i),
      .reg_addr_i (reg_addr_i),
      .reg_wdata_i(reg_wdata_i),
      .reg_rdata_o(reg_rdata_o),
      .s_tvalid_i (s_tvalid_i),
      .s_tdata_i  (s_tdata_i),
      .s_tready_o (s_tready_o),
      .awvalid_o  (awvalid_o),
      .awready_i  (awready_i),
      .awaddr_o   (awaddr_o),
      .awlen_o    (awlen_o),
      .wvalid_o   (wvalid_o),
      .wready_i   (wready_i),
      .wdata_o    (wdata_o),
      .wlast_o    (wlast_o),
      .bvalid_i   (bvalid_i),
      .bready_o   (bready_o),
      .busy_o     (busy_o)
   );

   initial begin
      forever #(CLK_HALF) clk_i = ~clk_i;
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         stop_run($sformatf("** Error at %0t: %s got 0x%08h expected 0x%08h",
                            $time, name, got, exp));
      end
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         stop_run($sformatf("** Error at %0t: %s got 0x%08h expected 0x%08h",
                            $time, name, got, exp));
      end
   endtask

   task automatic check_blen(input string name, input blen_t got, input blen_t exp);
      if (got !== exp) begin
         stop_run($sformatf("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp));
      end
   endtask

   task automatic check_word(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         stop_run($sformatf("** Error at %0t: %s got 0x%08h expected 0x%08h",
                            $time, name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("** Error at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   // Stream source, a word stays on the bus until the FIFO takes it
   always @(negedge clk_i) begin
      if (!s_tvalid_i || (src_idx != src_shown)) begin
         if ((src_idx < src_q.size()) && ($urandom_range(99) >= gap_pct)) begin
            s_tvalid_i = 1'b1;
            s_tdata_i  = src_q[src_idx];
            src_shown  = src_idx;
         end else begin
            s_tvalid_i = 1'b0;
         end
      end
   end

   always @(posedge clk_i) begin
      if (s_tvalid_i && s_tready_o) begin
         src_idx++;
      end
   end

   // Slave ready and response stalls
   always @(negedge clk_i) begin
      awready_i = ($urandom_range(99) >= stall_pct);
      wready_i  = ($urandom_range(99) >= stall_pct);
      if (!bvalid_i || (b_done != b_mark)) begin
         bvalid_i = (resp_len_q.size() > b_done) && ($urandom_range(99) >= stall_pct);
         b_mark   = b_done;
      end
   end

   always @(posedge clk_i) begin
      addr_t wr_addr;
      if (!s_tready_o) begin
         tready_low++;
      end
      if (bvalid_i && bready_o) begin
         acked += int'(resp_len_q[b_done]);
         b_done++;
      end
      if (awvalid_o && awready_i) begin
         aw_addr_q.push_back(awaddr_o);
         aw_len_q.push_back(blen_t'(awlen_o) + blen_t'(1));
      end
      if (wvalid_o && wready_i) begin
         if (w_idx >= aw_len_q.size()) begin
            stop_run("W beat arrived before its AW handshake");
         end else begin
            wr_addr = aw_addr_q[w_idx] + (addr_t'(w_beat) << 2);
            mem[wr_addr] = wdata_o;
            wr_addr_q.push_back(wr_addr);
            check_flag("wlast_o", wlast_o, blen_t'(w_beat + 1) == aw_len_q[w_idx]);
            if (wlast_o) begin
               resp_len_q.push_back(aw_len_q[w_idx]);
               w_idx++;
               w_beat = 0;
            end else begin
               w_beat++;
            end
         end
      end
   end

   task automatic reg_write(input logic [`DMA_REG_AW-1:0] addr, input data_t data);
      @(negedge clk_i);
      reg_wr_i    = 1'b1;
      reg_addr_i  = addr;
      reg_wdata_i = data;
      @(negedge clk_i);
      reg_wr_i = 1'b0;
   endtask

   task automatic reg_read(input logic [`DMA_REG_AW-1:0] addr, output data_t data);
      @(negedge clk_i);
      reg_addr_i = addr;
      @(negedge clk_i);
      data = reg_rdata_o;
   endtask

   task automatic run_transfer(input int idx);
      wlen_t len;
      blen_t maxl;
      addr_t addr;
      bit    bp;
      int    base_aw;
      int    base_wr;
      int    base_src;
      int    acked0;
      int    tlow0;
      int    unacked;
      int    n;
      wlen_t rem;
      addr_t a;
      blen_t b;
      data_t rd;
      len  = xfer_len[idx];
      maxl = xfer_max[idx];
      addr = xfer_addr[idx];
      // Last transfers run with heavy slave stalls
      bp   = (idx >= NUM_XFER - 2);
      @(posedge clk_i);
      base_aw  = aw_addr_q.size();
      base_wr  = wr_addr_q.size();
      base_src = src_q.size();
      acked0   = acked;
      tlow0    = tready_low;
      gap_pct   = bp ? 5 : $urandom_range(50);
      stall_pct = bp ? 80 : $urandom_range(40);
      for (int i = 0; i < int'(len); i++) begin
         src_q.push_back({word_seq[15:0], 16'($urandom())});
         word_seq++;
      end

      reg_write(`DMA_REG_ADDR, data_t'(addr));
      reg_write(`DMA_REG_LEN, data_t'(len));
      reg_write(`DMA_REG_MAXLEN, data_t'(maxl));
      reg_read(`DMA_REG_ADDR, rd);
      check_word("reg ADDR", rd, data_t'(addr));
      reg_read(`DMA_REG_LEN, rd);
      check_word("reg LEN", rd, data_t'(len));
      reg_read(`DMA_REG_MAXLEN, rd);
      check_word("reg MAXLEN", rd, data_t'(maxl));

      reg_write(`DMA_REG_CTRL, data_t'(1));
      reg_read(`DMA_REG_CTRL, rd);
      check_word("reg CTRL busy", rd, data_t'(1));
      // Second start lands while busy
      reg_write(`DMA_REG_CTRL, data_t'(1));

      @(negedge clk_i);
      reg_addr_i = `DMA_REG_REMAIN;
      do begin
         @(negedge clk_i);
         unacked = int'(len) - (acked - acked0);
         if (int'(reg_rdata_o) > unacked) begin
            stop_run($sformatf("** Error at %0t: reg REMAIN got %0d above unacknowledged %0d",
                               $time, reg_rdata_o, unacked));
         end
      end while (busy_o);
      if (acked - acked0 != int'(len)) begin
         stop_run($sformatf("Transfer %0d went idle with only %0d of %0d words acknowledged",
                            idx, acked - acked0, len));
      end
      check_word("reg REMAIN", reg_rdata_o, '0);
      reg_read(`DMA_REG_CTRL, rd);
      check_word("reg CTRL idle", rd, '0);

      // Expected bursts, max_len repeated then the tail
      rem = len;
      a   = addr;
      n   = base_aw;
      while (rem != '0) begin
         b = (rem > wlen_t'(maxl)) ? maxl : blen_t'(rem);
         if (n >= aw_addr_q.size()) begin
            stop_run($sformatf("Transfer %0d issued fewer AW bursts than expected", idx));
         end
         check_addr("awaddr_o", aw_addr_q[n], a);
         check_blen("awlen_o plus one", aw_len_q[n], b);
         rem = rem - wlen_t'(b);
         a   = a + (addr_t'(b) << 2);
         n++;
      end
      if (aw_addr_q.size() != n) begin
         stop_run($sformatf("Transfer %0d issued more AW bursts than expected", idx));
      end

      if (wr_addr_q.size() - base_wr != int'(len)) begin
         stop_run($sformatf("Transfer %0d wrote %0d words instead of %0d",
                            idx, wr_addr_q.size() - base_wr, len));
      end
      for (int i = 0; i < int'(len); i++) begin
         a = addr + (addr_t'(i) << 2);
         check_addr("write address", wr_addr_q[base_wr + i], a);
         check_data("memory word", mem[a], src_q[base_src + i]);
      end

      if (bp && (tready_low == tlow0)) begin
         stop_run($sformatf("Transfer %0d never saw s_tready_o drop under stalls", idx));
      end
   endtask

   // Watchdog sized from the total word count
   initial begin
      wait (total_words > 0);
      repeat (200 * total_words + 2000) @(posedge clk_i);
      stop_run($sformatf("Timeout: %0d transfers did not finish in time", NUM_XFER));
   end

   initial begin
      int unsigned seed_ret;
      seed_ret    = $urandom(SEED);
      arst_n_i    = 1'b0;
      reg_wr_i    = 1'b0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      gap_pct     = 0;
      stall_pct   = 0;
      word_seq    = 0;
      total_words = 0;
      for (int i = 0; i < NUM_XFER; i++) begin
         xfer_len[i]  = (i >= NUM_XFER - 2) ? wlen_t'(60) : wlen_t'($urandom_range(60, 1));
         xfer_max[i]  = blen_t'($urandom_range(16, 1));
         xfer_addr[i] = addr_t'($urandom() & 32'hffff_fffc);
         total_words  = total_words + int'(xfer_len[i]);
      end

      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;

      for (int i = 0; i < NUM_XFER; i++) begin
         run_transfer(i);
      end

      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: hdl/dma_write_top.sv
`timescale 1ns/1ps

`include "dma_write_consts.svh"

module dma_write_top
   import dma_write_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   // Register port
   input  logic                   reg_wr_i,
   input  logic [`DMA_REG_AW-1:0] reg_addr_i,
   input  data_t                  reg_wdata_i,
   output data_t                  reg_rdata_o,
   // Stream input
   input  logic                   s_tvalid_i,
   input  data_t                  s_tdata_i,
   output logic                   s_tready_o,
   // AXI4 write master
   output logic                   awvalid_o,
   input  logic                   awready_i,
   output addr_t                  awaddr_o,
   output logic [`DMA_BLEN_W-2:0] awlen_o,
   output logic                   wvalid_o,
   input  logic                   wready_i,
   output data_t                  wdata_o,
   output logic                   wlast_o,
   input  logic                   bvalid_i,
   output logic                   bready_o,
   output logic                   busy_o
);

   addr_t      cfg_addr;
   wlen_t      cfg_len;
   blen_t      cfg_max_len;
   logic       start;
   wlen_t      remain;
   logic       fifo_full;
   logic       fifo_wr;
   logic       fifo_rd;
   data_t      fifo_rdata;
   logic       fifo_empty;
   level_t     fifo_level;
   logic       stage_tvalid;
   data_t      stage_tdata;
   logic       stage_tready;
   logic [1:0] stage_level;
   addr_t      burst_addr;
   blen_t      burst_len;
   logic       burst_start;
   logic       wr_busy;

   assign s_tready_o = !fifo_full;
   assign fifo_wr    = s_tvalid_i && !fifo_full;

   dma_write_regs u_regs (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .reg_wr_i     (reg_wr_i),
      .reg_addr_i   (reg_addr_i),
      .reg_wdata_i  (reg_wdata_i),
      .busy_i       (busy_o),
      .remain_i     (remain),
      .reg_rdata_o  (reg_rdata_o),
      .cfg_addr_o   (cfg_addr),
      .cfg_len_o    (cfg_len),
      .cfg_max_len_o(cfg_max_len),
      .start_o      (start)
   );

   dma_write_fifo u_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .wr_en_i  (fifo_wr),
      .wr_data_i(s_tdata_i),
      .rd_en_i  (fifo_rd),
      .full_o   (fifo_full),
      .rd_data_o(fifo_rdata),
      .empty_o  (fifo_empty),
      .level_o  (fifo_level)
   );

   dma_write_fifo2axis u_fifo2axis (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .fifo_empty_i(fifo_empty),
      .fifo_rdata_i(fifo_rdata),
      .m_tready_i  (stage_tready),
      .fifo_rd_o   (fifo_rd),
      .m_tvalid_o  (stage_tvalid),
      .m_tdata_o   (stage_tdata),
      .level_o     (stage_level)
   );

   dma_write_burst_ctrl u_burst_ctrl (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .start_i      (start),
      .cfg_addr_i   (cfg_addr),
      .cfg_len_i    (cfg_len),
      .cfg_max_len_i(cfg_max_len),
      .fifo_level_i (fifo_level),
      .stage_level_i(stage_level),
      .wr_busy_i    (wr_busy),
      .busy_o       (busy_o),
      .remain_o     (remain),
      .burst_addr_o (burst_addr),
      .burst_len_o  (burst_len),
      .burst_start_o(burst_start)
   );

   dma_write_axi_wr u_axi_wr (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .burst_start_i(burst_start),
      .burst_addr_i (burst_addr),
      .burst_len_i  (burst_len),
      .s_tvalid_i   (stage_tvalid),
      .s_tdata_i    (stage_tdata),
      .awready_i    (awready_i),
      .wready_i     (wready_i),
      .bvalid_i     (bvalid_i),
      .busy_o       (wr_busy),
      .s_tready_o   (stage_tready),
      .awvalid_o    (awvalid_o),
      .awaddr_o     (awaddr_o),
      .awlen_o      (awlen_o),
      .wvalid_o     (wvalid_o),
      .wdata_o      (wdata_o),
      .wlast_o      (wlast_o),
      .bready_o     (bready_o)
   );

endmodule

// File: hdl/dma_write_axi_wr.sv
`timescale 1ns/1ps

`include "dma_write_consts.svh"

module dma_write_axi_wr
   import dma_write_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  logic                    burst_start_i,
   input  addr_t                   burst_addr_i,
   input  blen_t                   burst_len_i,
   input  logic                    s_tvalid_i,
   input  data_t                   s_tdata_i,
   input  logic                    awready_i,
   input  logic                    wready_i,
   input  logic                    bvalid_i,
   output logic                    busy_o,
   output logic                    s_tready_o,
   output logic                    awvalid_o,
   output addr_t                   awaddr_o,
   output logic [`DMA_BLEN_W-2:0]  awlen_o,
   output logic                    wvalid_o,
   output data_t                   wdata_o,
   output logic                    wlast_o,
   output logic                    bready_o
);

   localparam int AXLEN_W = `DMA_BLEN_W - 1;

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ADDR = 2'd1;
   localparam logic [1:0] ST_DATA = 2'd2;
   localparam logic [1:0] ST_RESP = 2'd3;

   logic [1:0] state;
   blen_t      beats_left;
   logic       w_fire;

   assign busy_o    = (state != ST_IDLE);
   assign awvalid_o = (state == ST_ADDR);
   assign bready_o  = (state == ST_RESP);

   // Stream goes straight onto W during the data phase only
   assign wvalid_o   = (state == ST_DATA) && s_tvalid_i;
   assign wdata_o    = s_tdata_i;
   assign s_tready_o = (state == ST_DATA) && wready_i;
   assign wlast_o    = (state == ST_DATA) && (beats_left == blen_t'(1));
   assign w_fire     = wvalid_o && wready_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state      <= ST_IDLE;
         beats_left <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (burst_start_i) begin
                  state      <= ST_ADDR;
                  beats_left <= burst_len_i;
               end
            end
            ST_ADDR: begin
               if (awready_i) begin
                  state <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (w_fire) begin
                  beats_left <= beats_left - 1'b1;
                  if (wlast_o) begin
                     state <= ST_RESP;
                  end
               end
            end
            default: begin
               if (bvalid_i) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // AW payload captured with the burst request
   always_ff @(posedge clk_i) begin
      if ((state == ST_IDLE) && burst_start_i) begin
         awaddr_o <= burst_addr_i;
         awlen_o  <= AXLEN_W'(burst_len_i - 1'b1);
      end
   end

   a_aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (awvalid_o && !awready_i) |=> (awvalid_o && $stable(awaddr_o) && $stable(awlen_o)));

endmodule

// File: hdl/dma_write_burst_ctrl.sv
`timescale 1ns/1ps

`include "dma_write_consts.svh"

module dma_write_burst_ctrl
   import dma_write_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic       start_i,
   input  addr_t      cfg_addr_i,
   input  wlen_t      cfg_len_i,
   input  blen_t      cfg_max_len_i,
   input  level_t     fifo_level_i,
   input  logic [1:0] stage_level_i,
   input  logic       wr_busy_i,
   output logic       busy_o,
   output wlen_t      remain_o,
   output addr_t      burst_addr_o,
   output blen_t      burst_len_o,
   output logic       burst_start_o
);

   localparam logic ST_IDLE      = 1'b0;
   localparam logic ST_WAIT_DATA = 1'b1;

   // FIFO plus stage, up to 18 words
   localparam int LVL_W = `DMA_FIFO_AW + 2;

   logic             state;
   logic             state_nxt;
   wlen_t            remain_nxt;
   addr_t            addr_nxt;
   logic [LVL_W-1:0] level;

   assign level  = LVL_W'(fifo_level_i) + LVL_W'(stage_level_i);
   assign busy_o = (state == ST_WAIT_DATA);

   always_comb begin
      state_nxt     = state;
      remain_nxt    = remain_o;
      addr_nxt      = burst_addr_o;
      burst_len_o   = '0;
      burst_start_o = 1'b0;

      case (state)
         ST_IDLE: begin
            if (start_i) begin
               remain_nxt = cfg_len_i;
               addr_nxt   = cfg_addr_i;
               state_nxt  = ST_WAIT_DATA;
            end
         end
         default: begin
            if (!wr_busy_i) begin
               if (remain_o == '0) begin
                  state_nxt = ST_IDLE;
               end else begin
                  // Tail burst when the rest is buffered and fits
                  if ((wlen_t'(level) >= remain_o) &&
                      (remain_o <= wlen_t'(cfg_max_len_i))) begin
                     burst_len_o = blen_t'(remain_o);
                  end else if (level >= LVL_W'(cfg_max_len_i)) begin
                     burst_len_o = cfg_max_len_i;
                  end

                  if (burst_len_o != '0) begin
                     burst_start_o = 1'b1;
                     remain_nxt    = remain_o - wlen_t'(burst_len_o);
                     addr_nxt      = burst_addr_o + (addr_t'(burst_len_o) << 2);
                  end
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state        <= ST_IDLE;
         remain_o     <= '0;
         burst_addr_o <= '0;
      end else begin
         state        <= state_nxt;
         remain_o     <= remain_nxt;
         burst_addr_o <= addr_nxt;
      end
   end

   a_burst_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      burst_start_o |-> (burst_len_o <= cfg_max_len_i));

   a_start_idle_writer: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      burst_start_o |-> !wr_busy_i);

endmodule

// File: hdl/dma_write_fifo2axis.sv
`timescale 1ns/1ps

module dma_write_fifo2axis
   import dma_write_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic       fifo_empty_i,
   input  data_t      fifo_rdata_i,
   input  logic       m_tready_i,
   output logic       fifo_rd_o,
   output logic       m_tvalid_o,
   output data_t      m_tdata_o,
   output logic [1:0] level_o
);

   // Word sitting on the FIFO read port, not yet taken
   logic held;
   logic load_out;

   // Output register is free or drains this cycle
   assign load_out = held && (!m_tvalid_o || m_tready_i);

   // Refill the read port as soon as its word moves on
   assign fifo_rd_o = !fifo_empty_i && (!held || load_out);

   assign level_o = {1'b0, held} + {1'b0, m_tvalid_o};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         held       <= 1'b0;
         m_tvalid_o <= 1'b0;
      end else begin
         held <= fifo_rd_o || (held && !load_out);
         if (load_out) begin
            m_tvalid_o <= 1'b1;
         end else if (m_tready_i) begin
            m_tvalid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (load_out) begin
         m_tdata_o <= fifo_rdata_i;
      end
   end

endmodule

// File: hdl/dma_write_fifo.sv
`timescale 1ns/1ps

`include "dma_write_consts.svh"

module dma_write_fifo
   import dma_write_pkg::*;
(
   input  logic   clk_i,
   input  logic   arst_n_i,
   input  logic   wr_en_i,
   input  data_t  wr_data_i,
   input  logic   rd_en_i,
   output logic   full_o,
   output data_t  rd_data_o,
   output logic   empty_o,
   output level_t level_o
);

   localparam int DEPTH = 1 << `DMA_FIFO_AW;

   data_t                   mem [DEPTH];
   logic [`DMA_FIFO_AW-1:0] wr_ptr;
   logic [`DMA_FIFO_AW-1:0] rd_ptr;

   assign full_o  = (level_o == level_t'(DEPTH));
   assign empty_o = (level_o == '0);

   // Storage and registered read port
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_ptr] <= wr_data_i;
      end
      if (rd_en_i) begin
         rd_data_o <= mem[rd_ptr];
      end
   end

   // Pointers wrap on their own
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         level_o <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en_i, rd_en_i})
            2'b10:   level_o <= level_o + 1'b1;
            2'b01:   level_o <= level_o - 1'b1;
            default: level_o <= level_o;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wr_en_i |-> !full_o);

   a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_en_i |-> !empty_o);

endmodule

// File: hdl/dma_write_regs.sv
`timescale 1ns/1ps

`include "dma_write_consts.svh"

module dma_write_regs
   import dma_write_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   reg_wr_i,
   input  logic [`DMA_REG_AW-1:0] reg_addr_i,
   input  data_t                  reg_wdata_i,
   input  logic                   busy_i,
   input  wlen_t                  remain_i,
   output data_t                  reg_rdata_o,
   output addr_t                  cfg_addr_o,
   output wlen_t                  cfg_len_o,
   output blen_t                  cfg_max_len_o,
   output logic                   start_o
);

   logic ctrl_wr;

   assign ctrl_wr = reg_wr_i && (reg_addr_i == `DMA_REG_CTRL) && reg_wdata_i[0];

   // Configuration registers
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cfg_addr_o    <= '0;
         cfg_len_o     <= '0;
         cfg_max_len_o <= '0;
      end else if (reg_wr_i) begin
         case (reg_addr_i)
            `DMA_REG_ADDR:   cfg_addr_o    <= addr_t'(reg_wdata_i);
            `DMA_REG_LEN:    cfg_len_o     <= wlen_t'(reg_wdata_i);
            `DMA_REG_MAXLEN: cfg_max_len_o <= blen_t'(reg_wdata_i);
            default: ;
         endcase
      end
   end

   // Start held off while busy or while a pulse is already out
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         start_o <= 1'b0;
      end else begin
         start_o <= ctrl_wr && !busy_i && !start_o;
      end
   end

   always_comb begin
      reg_rdata_o = '0;
      case (reg_addr_i)
         `DMA_REG_ADDR:   reg_rdata_o = data_t'(cfg_addr_o);
         `DMA_REG_LEN:    reg_rdata_o = data_t'(cfg_len_o);
         `DMA_REG_MAXLEN: reg_rdata_o = data_t'(cfg_max_len_o);
         `DMA_REG_CTRL:   reg_rdata_o = data_t'(busy_i);
         `DMA_REG_REMAIN: reg_rdata_o = data_t'(remain_i);
         default:         reg_rdata_o = '0;
      endcase
   end

   // Controller busy blocks any further start
   a_no_start_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      busy_i |-> !start_o);

endmodule

// File: hdl/dma_write_pkg.sv
`include "dma_write_consts.svh"

package dma_write_pkg;

   // Byte address on the AXI side
   typedef logic [`DMA_ADDR_W-1:0] addr_t;

   // One stream or AXI data word
   typedef logic [`DMA_DATA_W-1:0] data_t;

   // Transfer length and remaining count in words
   typedef logic [`DMA_LEN_W-1:0] wlen_t;

   // Burst length, 0 to 16 words
   typedef logic [`DMA_BLEN_W-1:0] blen_t;

   // FIFO fill level, one bit wider than the pointers
   typedef logic [`DMA_FIFO_AW:0] level_t;

endpackage

// File: hdl/dma_write_consts.svh
`ifndef DMA_WRITE_CONSTS_SVH
`define DMA_WRITE_CONSTS_SVH

// Data path and address widths
`define DMA_DATA_W 32
`define DMA_ADDR_W 32

// Transfer length in words
`define DMA_LEN_W 16

// AXI length field width plus one, covers 0 to 16
`define DMA_BLEN_W 5

// Buffer FIFO with 16 entries
`define DMA_FIFO_AW 4

// Register map
`define DMA_REG_AW 3

`define DMA_REG_ADDR   3'd0
`define DMA_REG_LEN    3'd1
`define DMA_REG_MAXLEN 3'd2
// Write bit 0 to start, read bit 0 for busy
`define DMA_REG_CTRL   3'd3
`define DMA_REG_REMAIN 3'd4

`endif
